// ==== test/fetch_golden.txt ====
// op pc prv word err stall vmask misaligned prot
// op 1 flushes before the fetch, stall is AR wait cycles
0 00001000 3 13000001 0 0 3 0 5
0 00001004 3 13000002 0 0 3 0 5
0 00001008 1 13000003 0 0 3 0 5
0 0000100a 1 13000004 0 0 2 0 5
0 0000100c 0 13000005 0 0 3 0 4
0 0000100e 0 13000006 0 1 2 0 4
0 00001011 3 13000007 0 0 3 1 5
0 00001013 0 13000008 0 0 2 1 4
0 00002000 3 deadbeef 1 0 3 0 5
0 00002004 1 cafe0001 0 0 3 0 5
0 00002008 3 cafe0002 0 6 3 0 5
0 0000200c 3 cafe0003 0 6 3 0 5
0 00002010 3 cafe0004 0 6 3 0 5
0 00002014 0 cafe0005 0 6 3 0 4
1 00003000 3 55aa0001 0 0 3 0 5
0 00003004 3 55aa0002 0 0 3 0 5
0 00003008 1 55aa0003 0 4 3 0 5
0 0000300c 1 55aa0004 1 4 3 0 5
1 00004000 0 66bb0001 0 0 3 0 4
0 00004002 0 66bb0002 0 0 2 0 4
0 00004004 3 66bb0003 0 2 3 0 5
0 00004006 3 66bb0004 0 2 2 0 5
0 00004008 1 66bb0005 0 3 3 0 5
1 0000400a 1 66bb0006 1 0 2 0 5
0 00005000 3 77cc0001 0 5 3 0 5
0 00005004 3 77cc0002 0 5 3 0 5
0 00005008 3 77cc0003 0 5 3 0 5
1 00005010 0 77cc0004 0 0 3 0 4
0 00005012 0 77cc0005 0 0 2 0 4
0 00005015 1 77cc0006 0 0 3 1 5
0 00005017 3 77cc0007 1 0 2 1 5
0 00006000 0 88dd0001 0 0 3 0 4

// ==== list.f ====
design/fetch_pkg.sv
design/fetch_queue.sv
design/fetch_nocache.sv
design/biu_axil_rd.sv
design/fetch_top.sv
test/fetch_assert.sv
test/tb_fetch.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the fetch testbench with Verilator
# Result is taken from the simulation log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module tb_fetch -f list.f -o sim_fetch \
  && ./obj_dir/sim_fetch | tee sim.log \
  || { echo "Build or simulation run failed"; exit 1; }

grep -q '\*\*\* PASSED \*\*\*' sim.log \
  && { echo "Simulation passed"; exit 0; } \
  || { echo "Simulation failed"; exit 1; }

// ==== test/tb_fetch.sv ====
//////////////////////////////
// Testbench for the fetch front end
// Golden file drives CPU side and AXI slave answers
// AXI slave answers in order, one R beat per AR
// Outputs sampled at the falling edge
//////////////////////////////

module tb_fetch;

  import fetch_pkg::*;

  // Golden file shape
  localparam int NLINES      = 32;
  localparam int NFIELDS     = 9;
  localparam int CYCLE_LIMIT = 40 * NLINES + 100;

  logic               clk_i;
  logic               rst_ni;
  logic [XLEN-1:0]    if_nxt_pc_i;
  logic               if_req_i;
  logic               if_ack_o;
  logic               if_flush_i;
  logic               dcflush_rdy_i;
  prv_t               st_prv_i;
  parcel_t            parcel_o;
  logic               arvalid_o;
  logic               arready_i;
  logic [XLEN-1:0]    araddr_o;
  prot_t              arprot_o;
  logic               rvalid_i;
  logic               rready_o;
  logic [XLEN-1:0]    rdata_i;
  logic [RESP_W-1:0]  rresp_i;

  logic [31:0]        gold [NLINES*NFIELDS];
  logic [31:0]        word;
  integer             seed;
  int                 cycle;
  int                 ln;
  int                 accepted;
  int                 responded;
  int                 checked;
  int                 stall_cnt;
  int                 gap_cnt;
  int                 idx;
  bit                 flush_done;
  int                 acc_cyc [NLINES];
  int                 flush_q [$];
  int                 ar_q [$];
  int                 r_q [$];
  int                 exp_ln_q [$];
  parcel_t            exp_q [$];
  parcel_t            exp_p;

  // Falling-edge copies of the handshakes
  logic               ack_s;
  logic               arvalid_s;
  logic               ar_hs_s;
  logic               r_hs_s;
  logic [XLEN-1:0]    araddr_s;
  prot_t              arprot_s;

  fetch_top dut (.*);

  bind fetch_top fetch_assert u_assert (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .arvalid_i  (arvalid_o),
    .arready_i  (arready_i),
    .araddr_i   (araddr_o),
    .parcel_i   (parcel_o),
    .inflight_i (u_core.inflight_q)
  );

  //////////////////////////////
  // Helpers
  //////////////////////////////

  function automatic logic [31:0] field(input int line, input int col);
    return gold[line*NFIELDS + col];
  endfunction

  // Dropped when a flush falls between accept and response
  function automatic bit is_dropped(input int acc, input int rsp);
    bit hit;
    hit = 1'b0;
    foreach (flush_q[k])
    begin
      if (acc < flush_q[k] && flush_q[k] <= rsp)
        hit = 1'b1;
    end
    return hit;
  endfunction

  function automatic parcel_t expect_parcel(input int line, input bit dropped);
    parcel_t     p;
    logic [31:0] vm;
    logic [31:0] mis;
    logic [31:0] err;
    vm           = field(line, 6);
    mis          = field(line, 7);
    err          = field(line, 4);
    p.pc         = field(line, 1);
    p.data       = field(line, 3);
    p.misaligned = mis[0];
    p.error      = err[0];
    // Errors and flushed reads never show valid code
    p.valid      = (dropped || err[0]) ? '0 : vm[PARCELS-1:0];
    return p;
  endfunction

  task automatic fail_now(input string why);
    $display("%s", why);
    $display("*** FAILED ***");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_parcel(input parcel_t act, input parcel_t exp, input int line);
    if (act !== exp)
      fail_now($sformatf({"[FAIL] parcel_o line %0d: pc %h/%h data %h/%h",
                          " valid %h/%h misaligned %h/%h error %h/%h (got/exp)"},
                         line, act.pc, exp.pc, act.data, exp.data, act.valid, exp.valid,
                         act.misaligned, exp.misaligned, act.error, exp.error));
  endtask

  task automatic check_prot(input prot_t act, input prot_t exp, input int line);
    if (act !== exp)
      fail_now($sformatf("[FAIL] arprot_o line %0d: got %h exp %h", line, act, exp));
  endtask

  task automatic check_addr(input logic [XLEN-1:0] act, input logic [XLEN-1:0] exp,
                            input int line);
    if (act !== exp)
      fail_now($sformatf("[FAIL] araddr_o line %0d: got %h exp %h", line, act, exp));
  endtask

  task automatic check_handshake(input logic act, input logic exp, input string name);
    if (act !== exp)
      fail_now($sformatf("[FAIL] %s: got %h exp %h", name, act, exp));
  endtask

  //////////////////////////////
  // Clock, reset, init
  //////////////////////////////

  initial
  begin
    clk_i = 1'b0;
  end

  always #4 clk_i = ~clk_i;

  initial
  begin
    seed          = 32'h7bffd1f9;
    $readmemh("test/fetch_golden.txt", gold);
    rst_ni        = 1'b0;
    if_nxt_pc_i   = '0;
    if_req_i      = 1'b0;
    if_flush_i    = 1'b0;
    dcflush_rdy_i = 1'b1;
    st_prv_i      = PRV_M;
    arready_i     = 1'b0;
    rvalid_i      = 1'b0;
    rdata_i       = '0;
    rresp_i       = '0;
    cycle         = 0;
    ln            = 0;
    accepted      = 0;
    responded     = 0;
    checked       = 0;
    stall_cnt     = 0;
    gap_cnt       = 0;
    flush_done    = 1'b0;
    ack_s         = 1'b0;
    arvalid_s     = 1'b0;
    ar_hs_s       = 1'b0;
    r_hs_s        = 1'b0;
    araddr_s      = '0;
    arprot_s      = '0;
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;
  end

  //////////////////////////////
  // Driver and AXI slave
  //////////////////////////////

  always @(posedge clk_i)
  begin
    if (rst_ni)
    begin
      cycle = cycle + 1;
      if (cycle > CYCLE_LIMIT)
        fail_now($sformatf("Run timed out after %0d cycles", cycle));
      // Request taken in the last cycle
      if (ack_s)
      begin
        acc_cyc[ln] = cycle - 1;
        ar_q.push_back(ln);
        accepted   = accepted + 1;
        ln         = ln + 1;
        flush_done = 1'b0;
        if (accepted - responded > DEPTH)
          fail_now("More reads acknowledged than the bridge may keep outstanding");
      end
      // CPU side, optional one-cycle flush before a fetch
      if (ln >= NLINES)
      begin
        if_req_i   <= 1'b0;
        if_flush_i <= 1'b0;
      end
      else
      begin
        word = field(ln, 0);
        if (word[0] && !flush_done)
        begin
          if_req_i   <= 1'b0;
          if_flush_i <= 1'b1;
          flush_q.push_back(cycle);
          flush_done = 1'b1;
        end
        else
        begin
          if_flush_i  <= 1'b0;
          if_req_i    <= 1'b1;
          if_nxt_pc_i <= field(ln, 1);
          word = field(ln, 2);
          st_prv_i    <= prv_t'(word[1:0]);
        end
      end
      // AR channel, arready held back by the listed stall
      if (ar_hs_s)
      begin
        idx  = ar_q.pop_front();
        word = field(idx, 8);
        check_addr(araddr_s, field(idx, 1), idx);
        check_prot(arprot_s, word[2:0], idx);
        r_q.push_back(idx);
        arready_i <= 1'b0;
        stall_cnt = 0;
      end
      else if (arvalid_s && !arready_i && ar_q.size() > 0)
      begin
        if (stall_cnt >= int'(field(ar_q[0], 5)))
          arready_i <= 1'b1;
        else
          stall_cnt = stall_cnt + 1;
      end
      // R channel with random gaps
      if (r_hs_s)
      begin
        idx       = r_q.pop_front();
        responded = responded + 1;
        // Registered response shows in this cycle
        exp_q.push_back(expect_parcel(idx, is_dropped(acc_cyc[idx], cycle)));
        exp_ln_q.push_back(idx);
        rvalid_i <= 1'b0;
        gap_cnt = $unsigned($random(seed)) % 3;
      end
      else if (!rvalid_i && r_q.size() > 0)
      begin
        if (gap_cnt > 0)
          gap_cnt = gap_cnt - 1;
        else
        begin
          word = field(r_q[0], 4);
          rvalid_i <= 1'b1;
          rdata_i  <= field(r_q[0], 3);
          rresp_i  <= word[0] ? 2'b10 : 2'b00;
        end
      end
    end
  end

  //////////////////////////////
  // Sampling and parcel checks
  //////////////////////////////

  always @(negedge clk_i)
  begin
    ack_s     = if_ack_o;
    arvalid_s = arvalid_o;
    ar_hs_s   = arvalid_o & arready_i;
    araddr_s  = araddr_o;
    arprot_s  = arprot_o;
    r_hs_s    = rvalid_i & rready_o;
    if (rst_ni)
    begin
      // Valid while an AR waits, ready while any read is owed
      check_handshake(arvalid_o, ar_q.size() > 0, "arvalid_o");
      check_handshake(rready_o, accepted != responded, "rready_o");
      if (exp_q.size() > 0)
      begin
        exp_p = exp_q.pop_front();
        check_parcel(parcel_o, exp_p, exp_ln_q.pop_front());
        checked = checked + 1;
        if (checked == NLINES)
        begin
          $display("*** PASSED ***");
          $finish;
        end
      end
      else if (parcel_o.valid != '0 || parcel_o.error)
        fail_now("Parcel output active in a cycle with no response due");
    end
  end

endmodule

// ==== test/fetch_assert.sv ====
//////////////////////////////
// Bound checks on the fetch top level
// AR stability, in-flight bound, quiet parcels at reset
//////////////////////////////

module fetch_assert (
  input logic                           clk_i,
  input logic                           rst_ni,
  input logic                           arvalid_i,
  input logic                           arready_i,
  input logic [fetch_pkg::XLEN-1:0]     araddr_i,
  input fetch_pkg::parcel_t             parcel_i,
  input logic [fetch_pkg::CNT_W-1:0]    inflight_i
);

  import fetch_pkg::*;

  // AR beat held until taken
  ar_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    arvalid_i && !arready_i |=> arvalid_i && $stable(araddr_i))
    else $error("AR valid or address changed before arready");

  // Core never owes more than DEPTH reads
  inflight_max: assert property (@(posedge clk_i) disable iff (!rst_ni)
    inflight_i <= CNT_W'(DEPTH))
    else $error("Reads in flight above DEPTH");

  // Quiet output during reset
  parcel_rst: assert property (@(posedge clk_i)
    !rst_ni |-> parcel_i.valid == '0)
    else $error("Parcel valid during reset");

  // And in the first cycle out of reset
  parcel_rel: assert property (@(posedge clk_i)
    $rose(rst_ni) |-> parcel_i.valid == '0)
    else $error("Parcel valid right after reset");

endmodule

// ==== design/fetch_top.sv ====
//////////////////////////////
// Fetch front end, core plus AXI4-Lite read bridge
// External slave must follow AXI4-Lite read ordering
//////////////////////////////

module fetch_top (
  input  logic                         clk_i,
  input  logic                         rst_ni,

  // CPU side
  input  logic [fetch_pkg::XLEN-1:0]   if_nxt_pc_i,
  input  logic                         if_req_i,
  output logic                         if_ack_o,
  input  logic                         if_flush_i,
  input  logic                         dcflush_rdy_i,
  input  fetch_pkg::prv_t              st_prv_i,
  output fetch_pkg::parcel_t           parcel_o,

  // AXI4-Lite read master
  output logic                         arvalid_o,
  input  logic                         arready_i,
  output logic [fetch_pkg::XLEN-1:0]   araddr_o,
  output fetch_pkg::prot_t             arprot_o,
  input  logic                         rvalid_i,
  output logic                         rready_o,
  input  logic [fetch_pkg::XLEN-1:0]   rdata_i,
  input  logic [fetch_pkg::RESP_W-1:0] rresp_i
);

  import fetch_pkg::*;

  // Internal strobe/ack bus
  logic       biu_stb;
  logic       biu_stb_ack;
  fetch_req_t biu_req;
  logic       biu_rsp_valid;
  fetch_rsp_t biu_rsp;

  fetch_nocache u_core (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .if_nxt_pc_i     (if_nxt_pc_i),
    .if_req_i        (if_req_i),
    .if_ack_o        (if_ack_o),
    .if_flush_i      (if_flush_i),
    .dcflush_rdy_i   (dcflush_rdy_i),
    .st_prv_i        (st_prv_i),
    .parcel_o        (parcel_o),
    .biu_stb_o       (biu_stb),
    .biu_req_o       (biu_req),
    .biu_stb_ack_i   (biu_stb_ack),
    .biu_rsp_valid_i (biu_rsp_valid),
    .biu_rsp_i       (biu_rsp)
  );

  biu_axil_rd u_biu (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .biu_stb_i       (biu_stb),
    .biu_req_i       (biu_req),
    .biu_stb_ack_o   (biu_stb_ack),
    .biu_rsp_valid_o (biu_rsp_valid),
    .biu_rsp_o       (biu_rsp),
    .arvalid_o       (arvalid_o),
    .arready_i       (arready_i),
    .araddr_o        (araddr_o),
    .arprot_o        (arprot_o),
    .rvalid_i        (rvalid_i),
    .rready_o        (rready_o),
    .rdata_i         (rdata_i),
    .rresp_i         (rresp_i)
  );

endmodule

// ==== design/biu_axil_rd.sv ====
//////////////////////////////
// Strobe/ack to AXI4-Lite read master
// Read channels only, no write, burst or lock
// Up to DEPTH reads outstanding, responses in issue order
// Response registered, one cycle after the R beat
//////////////////////////////

module biu_axil_rd (
  input  logic                         clk_i,
  input  logic                         rst_ni,

  // Strobe/ack bus from the fetch core
  input  logic                         biu_stb_i,
  input  fetch_pkg::fetch_req_t        biu_req_i,
  output logic                         biu_stb_ack_o,
  output logic                         biu_rsp_valid_o,
  output fetch_pkg::fetch_rsp_t        biu_rsp_o,

  // AXI4-Lite AR channel
  output logic                         arvalid_o,
  input  logic                         arready_i,
  output logic [fetch_pkg::XLEN-1:0]   araddr_o,
  output fetch_pkg::prot_t             arprot_o,

  // AXI4-Lite R channel
  input  logic                         rvalid_i,
  output logic                         rready_o,
  input  logic [fetch_pkg::XLEN-1:0]   rdata_i,
  input  logic [fetch_pkg::RESP_W-1:0] rresp_i
);

  import fetch_pkg::*;

  // Outstanding address payload
  typedef logic [XLEN-1:0] addr_t;

  fetch_req_t ar_head;
  addr_t      addr_head;
  logic       ar_full;
  logic       ar_empty;
  logic       addr_full;
  logic       addr_empty;
  logic       accept;
  logic       ar_fire;
  logic       r_fire;

  //////////////////////////////
  // Request acceptance
  //////////////////////////////

  // Both queues need room, address queue caps outstanding reads
  assign biu_stb_ack_o = biu_stb_i & ~ar_full & ~addr_full;
  assign accept        = biu_stb_ack_o;

  // Pending AR beats
  fetch_queue #(
    .T     (fetch_req_t),
    .DEPTH (DEPTH)
  ) u_ar_queue (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (accept),
    .data_i  (biu_req_i),
    .full_o  (ar_full),
    .pop_i   (ar_fire),
    .data_o  (ar_head),
    .empty_o (ar_empty)
  );

  // Addresses awaiting their R beat, oldest at the head
  fetch_queue #(
    .T     (addr_t),
    .DEPTH (DEPTH)
  ) u_addr_queue (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (accept),
    .data_i  (biu_req_i.addr),
    .full_o  (addr_full),
    .pop_i   (r_fire),
    .data_o  (addr_head),
    .empty_o (addr_empty)
  );

  //////////////////////////////
  // AR channel
  //////////////////////////////

  // Head held stable until arready since the queue only pops on handshake
  assign arvalid_o = ~ar_empty;
  assign araddr_o  = ar_head.addr;
  assign arprot_o  = ar_head.prot;
  assign ar_fire   = arvalid_o & arready_i;

  //////////////////////////////
  // R channel
  //////////////////////////////

  // Ready whenever a read is owed
  assign rready_o = ~addr_empty;
  assign r_fire   = rvalid_i & rready_o;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      biu_rsp_valid_o <= 1'b0;
    else
      biu_rsp_valid_o <= r_fire;
  end

  // Pair the beat with its own address
  always_ff @(posedge clk_i)
  begin
    if (r_fire)
    begin
      biu_rsp_o.addr <= addr_head;
      biu_rsp_o.data <= rdata_i;
      // SLVERR and DECERR both set the top bit
      biu_rsp_o.err  <= rresp_i[RESP_W-1];
    end
  end

endmodule

// ==== design/fetch_nocache.sv ====
//////////////////////////////
// Fetch core for a cacheless RISC-V front end
// Strobe is combinational, bridge must ack in the same cycle
// Responses must return one per request, in order
// Parcels after a flush are dropped, errors still flagged
//////////////////////////////

module fetch_nocache (
  input  logic                         clk_i,
  input  logic                         rst_ni,

  // CPU side
  input  logic [fetch_pkg::XLEN-1:0]   if_nxt_pc_i,
  input  logic                         if_req_i,
  output logic                         if_ack_o,
  input  logic                         if_flush_i,
  input  logic                         dcflush_rdy_i,
  input  fetch_pkg::prv_t              st_prv_i,
  output fetch_pkg::parcel_t           parcel_o,

  // Strobe/ack bus to the bridge
  output logic                         biu_stb_o,
  output fetch_pkg::fetch_req_t        biu_req_o,
  input  logic                         biu_stb_ack_i,
  input  logic                         biu_rsp_valid_i,
  input  fetch_pkg::fetch_rsp_t        biu_rsp_i
);

  import fetch_pkg::*;

  logic             stb_accept;
  prot_t            prot_priv;
  logic             flush_dly_q;
  logic [CNT_W-1:0] inflight_q;
  logic [CNT_W-1:0] discard_q;
  logic             show_parcel;

  //////////////////////////////
  // Request gating
  //////////////////////////////

  // No new fetch while the D-cache flushes or the pipe flushes
  assign biu_stb_o  = dcflush_rdy_i & ~if_flush_i & if_req_i;
  assign stb_accept = biu_stb_o & biu_stb_ack_i;

  // CPU may advance its PC
  assign if_ack_o = stb_accept;

  // Privileged unless running in user mode
  assign prot_priv = (st_prv_i == PRV_U) ? prot_t'(3'b000) : PROT_PRIVILEGED;

  assign biu_req_o.addr = if_nxt_pc_i;
  assign biu_req_o.prot = PROT_INSTRUCTION | prot_priv;

  //////////////////////////////
  // In-flight and discard tracking
  //////////////////////////////

  // Flush hides parcels for one more cycle
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      flush_dly_q <= 1'b0;
    else
      flush_dly_q <= if_flush_i;
  end

  // Up on accept, down on response
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      inflight_q <= '0;
    else
    begin
      case ({stb_accept, biu_rsp_valid_i})
        2'b10:   inflight_q <= inflight_q + 1'b1;
        2'b01:   inflight_q <= inflight_q - 1'b1;
        default: inflight_q <= inflight_q;
      endcase
    end
  end

  // Reads still owed at flush time get dropped on return
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      discard_q <= '0;
    else if (if_flush_i)
    begin
      // A response landing in the flush cycle is already hidden
      if ((|inflight_q) && biu_rsp_valid_i)
        discard_q <= inflight_q - 1'b1;
      else
        discard_q <= inflight_q;
    end
    else if ((|discard_q) && biu_rsp_valid_i)
      discard_q <= discard_q - 1'b1;
  end

  //////////////////////////////
  // Parcel output
  //////////////////////////////

  // Good data, not flushed, nothing left to drop
  assign show_parcel = dcflush_rdy_i & ~(if_flush_i | flush_dly_q) &
                       biu_rsp_valid_i & ~biu_rsp_i.err & ~(|discard_q);

  assign parcel_o.pc    = biu_rsp_i.addr;
  assign parcel_o.data  = biu_rsp_i.data;
  // Errors report even when the parcel is discarded
  assign parcel_o.error = biu_rsp_valid_i & biu_rsp_i.err;

  // PC bit 1 set means only the upper parcel holds code
  assign parcel_o.valid = show_parcel ?
                          {PARCELS{1'b1}} << biu_rsp_i.addr[1 +: PARCEL_SEL_W] :
                          {PARCELS{1'b0}};

  // With RVC only odd byte addresses misalign
  assign parcel_o.misaligned = HAS_RVC ? biu_rsp_i.addr[0] : |biu_rsp_i.addr[1:0];

endmodule

// ==== design/fetch_queue.sv ====
//////////////////////////////
// Small synchronous FIFO, payload type set by parameter
// Push while full and pop while empty are ignored
// data_o shows the head whenever not empty
//////////////////////////////

module fetch_queue #(
  parameter type         T     = logic,
  parameter int unsigned DEPTH = 2
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic push_i,
  input  T     data_i,
  output logic full_o,
  input  logic pop_i,
  output T     data_o,
  output logic empty_o
);

  // Pointer and fill widths follow this instance's depth
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned FILL_W = $clog2(DEPTH + 1);

  T                  mem_q [DEPTH];
  logic [PTR_W-1:0]  wr_ptr_q;
  logic [PTR_W-1:0]  rd_ptr_q;
  logic [FILL_W-1:0] count_q;
  logic              do_push;
  logic              do_pop;

  // Pointer step with wrap at DEPTH
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1))
      return '0;
    return ptr + 1'b1;
  endfunction

  assign full_o  = (count_q == FILL_W'(DEPTH));
  assign empty_o = (count_q == '0);
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;
  assign data_o  = mem_q[rd_ptr_q];

  // Storage
  always_ff @(posedge clk_i)
  begin
    if (do_push)
      mem_q[wr_ptr_q] <= data_i;
  end

  // Pointers and fill level
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (do_pop)
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      // Simultaneous push and pop keeps the count
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

// ==== design/fetch_pkg.sv ====
//////////////////////////////
// Widths, privilege and protection codes, fetch payloads
// XLEN fixed at 32, no 64-bit support
// DEPTH bounds reads in flight on both core and bridge
// RVC setting fixed at elaboration
//////////////////////////////

package fetch_pkg;

  //////////////////////////////
  // Bus widths
  //////////////////////////////

  // Data and address width
  localparam int XLEN         = 32;
  // Instruction parcel width
  localparam int PARCEL_SIZE  = 16;
  localparam int PARCELS      = XLEN / PARCEL_SIZE;
  // PC bits that select the first valid parcel
  localparam int PARCEL_SEL_W = $clog2(PARCELS);

  // Compressed instructions allowed, PC bit 0 alone marks misalignment
  localparam bit HAS_RVC      = 1'b1;

  // Max reads in flight
  localparam int DEPTH        = 2;
  // Counter width, holds 0..DEPTH
  localparam int CNT_W        = $clog2(DEPTH + 1);

  // AXI response width, top bit flags an error
  localparam int RESP_W       = 2;

  //////////////////////////////
  // Privilege and protection
  //////////////////////////////

  typedef enum logic [1:0] {
    PRV_U = 2'b00,
    PRV_S = 2'b01,
    PRV_M = 2'b11
  } prv_t;

  // AXI AxPROT encoding
  typedef logic [2:0] prot_t;

  localparam prot_t PROT_PRIVILEGED  = 3'b001;
  localparam prot_t PROT_INSTRUCTION = 3'b100;

  //////////////////////////////
  // Payloads
  //////////////////////////////

  // Core to bridge, becomes the AR beat
  typedef struct packed {
    logic [XLEN-1:0] addr;
    prot_t           prot;
  } fetch_req_t;

  // Bridge to core, one per accepted request, in order
  typedef struct packed {
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] data;
    logic            err;
  } fetch_rsp_t;

  // CPU-side result
  typedef struct packed {
    logic [XLEN-1:0]    pc;
    logic [XLEN-1:0]    data;
    logic [PARCELS-1:0] valid;
    logic               misaligned;
    logic               error;
  } parcel_t;

endpackage
